// File: hw/cart_pkg.sv
/*
 * shared definitions for the cartridge mapper
 *  - widths of banks, offsets and byte addresses
 *  - header offsets and the RAM enable key
 *  - mapper kind and address region enums, region decode function
 *  - packed structs for download beats, console bus, header info, bank state
 *  - reset values of header info and bank state
 */
package cart_pkg;

	// ------------------------------
	// widths
	localparam int DL_ADDR_W  = 25;                     // download byte address
	localparam int DL_DATA_W  = 16;                     // download beat is one word
	localparam int BUS_ADDR_W = 16;                     // console address space
	localparam int ROM_BANK_W = 9;                      // up to 512 banks (MBC5)
	localparam int RAM_BANK_W = 4;                      // up to 16 banks of 8k
	localparam int ROM_OFS_W  = 14;                     // 16k per ROM bank
	localparam int RAM_OFS_W  = 13;                     // 8k per RAM bank
	localparam int ROM_ADDR_W = ROM_BANK_W + ROM_OFS_W; // 8 MB of ROM
	localparam int RAM_ADDR_W = RAM_BANK_W + RAM_OFS_W; // 128 KB of RAM

	// header words, addressed by the even byte of the word
	localparam logic [DL_ADDR_W-1:0] HDR_MBC_TYPE = 25'h146; // type byte sits in the high half
	localparam logic [DL_ADDR_W-1:0] HDR_SIZES    = 25'h148; // low = ROM size, high = RAM size
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

	typedef enum logic [2:0] {
		mbc_none, mbc_1, mbc_2, mbc_3, mbc_5
	} mbc_kind_t;

	// 8k regions picked by address bits 15:13
	typedef enum logic [2:0] {
		rgn_ram_enable, // 0000-1FFF
		rgn_rom_bank,   // 2000-3FFF
		rgn_ram_bank,   // 4000-5FFF
		rgn_mode,       // 6000-7FFF
		rgn_rom_high0,  // 8000-9FFF, first block above ROM, not served here
		rgn_cram,       // A000-BFFF
		rgn_other       // C000 and up
	} cart_region_t;

	// ------------------------------
	typedef struct packed {
		logic                 wr;   // one strobe per word
		logic [DL_ADDR_W-1:0] addr;
		logic [DL_DATA_W-1:0] data;
	} dl_word_t;

	typedef struct packed {
		logic [BUS_ADDR_W-1:0] addr;
		logic                  rd;
		logic                  wr;
		logic [7:0]            di;
	} cart_bus_t;

	typedef struct packed {
		mbc_kind_t             kind;
		logic [ROM_BANK_W-1:0] rom_mask;
		logic [RAM_BANK_W-1:0] ram_mask;
	} cart_info_t;

	typedef struct packed {
		logic [ROM_BANK_W-1:0] rom_bank;
		logic [RAM_BANK_W-1:0] ram_bank;
		logic                  ram_enable;
		logic                  mbc1_mode;  // 0: RAM bank bits extend the ROM bank
		logic                  rtc_sel;    // MBC3 clock register mapped at A000
	} bank_state_t;

	localparam cart_info_t  INFO_RESET = '{kind: mbc_none, rom_mask: '0, ram_mask: '0};
	localparam bank_state_t BANK_RESET = '{rom_bank: 9'd1, ram_bank: '0, ram_enable: 1'b0,
		mbc1_mode: 1'b0, rtc_sel: 1'b0};

	function automatic cart_region_t region_of(input logic [BUS_ADDR_W-1:0] addr);
		case (addr[15:13])
			3'b000:  return rgn_ram_enable;
			3'b001:  return rgn_rom_bank;
			3'b010:  return rgn_ram_bank;
			3'b011:  return rgn_mode;
			3'b100:  return rgn_rom_high0;
			3'b101:  return rgn_cram;
			default: return rgn_other;
		endcase
	endfunction

endpackage

// File: hw/cart_header.sv
/*
 * cartridge header capture
 *  - grabs the type byte and the size word while the ROM streams in
 *  - decodes the mapper kind from the type code
 *  - decodes ROM and RAM bank masks from the size codes
 */
module cart_header (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::dl_word_t   dl,
	input  logic                 dl_active,
	output cart_pkg::cart_info_t info
);
	import cart_pkg::*;

	logic hdr_wr;   // beat of the cartridge image, not of some other file
	logic type_hit;
	logic size_hit;

	// ------------------------------
	// decode helpers

	// type codes, as listed in the cartridge header spec
	function automatic mbc_kind_t kind_of(input logic [7:0] code);
		case (code) inside
			[8'd1:8'd3]:   return mbc_1;   // plain, +RAM, +RAM+battery
			[8'd5:8'd6]:   return mbc_2;
			[8'd15:8'd19]: return mbc_3;   // with and without timer
			[8'd25:8'd30]: return mbc_5;   // incl. rumble variants
			default:       return mbc_none; // ROM only and unsupported mappers
		endcase
	endfunction

	// 0 -> 2 banks ... 8 -> 512 banks, one mask bit per doubling
	function automatic logic [ROM_BANK_W-1:0] rom_mask_of(input logic [7:0] code);
		if (code <= 8'd8) begin
			return 9'h1FF >> (4'd8 - code[3:0]);
		end
		return 9'd127; // odd sizes 52h..54h, round up to 128 banks
	endfunction

	function automatic logic [RAM_BANK_W-1:0] ram_mask_of(input logic [7:0] code);
		if (code < 8'd3) begin
			return 4'b0000;  // none, 2k or 8k: single bank
		end
		if (code == 8'd3) begin
			return 4'b0011;  // 32k in 4 banks
		end
		return 4'b1111;      // 128k in 16 banks
	endfunction

	// ------------------------------
	assign hdr_wr   = dl.wr & dl_active;
	assign type_hit = hdr_wr && (dl.addr == HDR_MBC_TYPE);
	assign size_hit = hdr_wr && (dl.addr == HDR_SIZES);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			info <= INFO_RESET;
		end else begin
			if (type_hit) begin
				info.kind <= kind_of(dl.data[15:8]); // byte 147h
			end
			if (size_hit) begin
				info.rom_mask <= rom_mask_of(dl.data[7:0]);  // byte 148h
				info.ram_mask <= ram_mask_of(dl.data[15:8]); // byte 149h
			end
		end
	end

endmodule

// File: hw/mbc_regs.sv
/*
 * mapper register file
 *  - console writes to 0000-7FFF land here
 *  - RAM enable, ROM bank, RAM bank / RTC select, MBC1 mode
 *  - held at reset values during reset and cartridge download
 */
module mbc_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  cart_pkg::cart_bus_t   bus,
	input  cart_pkg::cart_info_t  info,
	output cart_pkg::bank_state_t banks
);
	import cart_pkg::*;

	cart_region_t rgn;  // which register the write goes to
	logic         is_mbc5;

	assign rgn     = region_of(bus.addr);
	assign is_mbc5 = (info.kind == mbc_5);

	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			banks <= BANK_RESET; // a new image always starts from bank 1
		end else if (bus.wr) begin
			case (rgn)
				// any value other than the key switches RAM off again
				rgn_ram_enable: begin
					banks.ram_enable <= (bus.di[3:0] == RAM_ENABLE_KEY);
				end

				rgn_rom_bank: begin
					if (is_mbc5) begin
						if (bus.addr[12]) begin
							banks.rom_bank[8] <= bus.di[0];         // 3000-3FFF high bit
						end else begin
							banks.rom_bank[7:0] <= bus.di;          // 2000-2FFF low byte
						end
					end else if (bus.di[6:0] == 7'd0) begin
						banks.rom_bank <= 9'd1;                      // bank 0 aliases to 1
					end else begin
						banks.rom_bank <= {2'b00, bus.di[6:0]};
					end
				end

				rgn_ram_bank: begin
					case (info.kind)
						mbc_3: begin
							// codes 08..0C pick a clock register instead of RAM
							if (bus.di[3]) begin
								banks.rtc_sel <= 1'b1;
							end else begin
								banks.rtc_sel  <= 1'b0;
								banks.ram_bank <= {2'b00, bus.di[1:0]};
							end
						end
						mbc_5: begin
							banks.ram_bank <= bus.di[3:0];          // 16 banks
						end
						default: begin
							banks.ram_bank <= {2'b00, bus.di[1:0]}; // MBC1: 2 bits, shared
						end
					endcase
				end

				// only MBC1 has the ROM/RAM banking mode switch
				rgn_mode: begin
					if (info.kind == mbc_1) begin
						banks.mbc1_mode <= bus.di[0];
					end
				end

				default: begin
					// writes above 7FFF hit RAM or nothing
				end
			endcase
		end
	end

endmodule

// File: hw/bank_map.sv
/*
 * address mapping, purely combinational
 *  - console address + bank state -> ROM byte address
 *  - console address + bank state -> cartridge RAM address
 *  - ROM read strobe and cartridge RAM select
 */
module bank_map (
	input  cart_pkg::cart_bus_t             bus,
	input  cart_pkg::cart_info_t            info,
	input  cart_pkg::bank_state_t           banks,
	output logic [cart_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic                            rom_rd,
	output logic [cart_pkg::RAM_ADDR_W-1:0] ram_addr,
	output logic                            ram_sel
);
	import cart_pkg::*;

	cart_region_t          rgn;
	logic [6:0]            mbc1_bank;    // 7-bit MBC1 bank before masking
	logic [ROM_BANK_W-1:0] eff_bank;     // bank seen at 4000-7FFF
	logic [ROM_BANK_W-1:0] rom_bank_sel; // bank for the current address
	logic [RAM_BANK_W-1:0] ram_bank_sel;

	assign rgn = region_of(bus.addr);

	// ------------------------------
	// ROM side

	// mode 0: RAM bank reg drives ROM bank bits 6:5, mode 1: they read as 0
	assign mbc1_bank = {banks.mbc1_mode ? 2'b00 : banks.ram_bank[1:0], banks.rom_bank[4:0]};

	always_comb begin
		case (info.kind)
			mbc_1:        eff_bank = {2'b00, mbc1_bank} & info.rom_mask;
			mbc_2, mbc_3: eff_bank = {2'b00, banks.rom_bank[6:0]} & info.rom_mask;
			mbc_5:        eff_bank = banks.rom_bank & info.rom_mask; // bank 0 allowed
			default:      eff_bank = 9'd1; // no mapper, 32k linear
		endcase
	end

	// 0000-3FFF is always bank 0
	assign rom_bank_sel = bus.addr[14] ? eff_bank : '0;
	assign rom_addr     = {rom_bank_sel, bus.addr[ROM_OFS_W-1:0]};
	assign rom_rd       = bus.rd & ~bus.addr[15];

	// ------------------------------
	// RAM side

	always_comb begin
		case (info.kind)
			mbc_1: begin
				// RAM only banks in mode 1, mode 0 gives the bits to ROM
				ram_bank_sel = banks.mbc1_mode ? (banks.ram_bank & info.ram_mask) : '0;
			end
			mbc_3, mbc_5: begin
				ram_bank_sel = banks.ram_bank & info.ram_mask;
			end
			default: begin
				ram_bank_sel = '0;  // MBC2 512x4 on chip, or plain 8k
			end
		endcase
	end

	assign ram_addr = {ram_bank_sel, bus.addr[RAM_OFS_W-1:0]};
	assign ram_sel  = (rgn == rgn_cram);

endmodule

// File: hw/cart_ram.sv
/*
 * banked cartridge RAM, 16 x 8k bytes
 *  - byte writes from the console bus
 *  - registered read data, one cycle after the read strobe
 *  - disabled RAM, RTC select and MBC2 nibble masking on the way out
 */
module cart_ram (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  cart_pkg::cart_bus_t             bus,
	input  cart_pkg::cart_info_t            info,
	input  cart_pkg::bank_state_t           banks,
	input  logic [cart_pkg::RAM_ADDR_W-1:0] ram_addr,
	input  logic                            ram_sel,
	output logic [7:0]                      cart_do
);
	import cart_pkg::*;

	logic [7:0] mem [0:(1 << RAM_ADDR_W)-1];
	logic [7:0] ram_q;    // raw byte of the last read
	logic       rd_hit;
	logic       out_off;  // RAM disabled at read time
	logic       out_zero; // clock register selected, no RTC behind it
	logic       out_nib;  // MBC2 RAM is only 4 bits wide

	assign rd_hit = ram_sel & bus.rd;

	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (ram_sel && bus.wr) begin
			mem[ram_addr] <= bus.di;
		end
		if (rd_hit) begin
			ram_q <= mem[ram_addr];
		end
	end

	// output shaping, sampled with the read so cart_do holds until the next one
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_off  <= 1'b1;   // floats high like an empty slot
			out_zero <= 1'b0;
			out_nib  <= 1'b0;
		end else if (rd_hit) begin
			out_off  <= ~banks.ram_enable;
			out_zero <= (info.kind == mbc_3) && banks.rtc_sel;
			out_nib  <= (info.kind == mbc_2) && (bus.addr[15:9] == 7'b1010000); // A000-A1FF
		end
	end

	assign cart_do = out_off  ? 8'hFF :
	                 out_zero ? 8'h00 :
	                 out_nib  ? {4'hF, ram_q[3:0]} :
	                 ram_q;

endmodule

// File: hw/gb_cart_mbc.sv
/*
 * cartridge mapper top level
 *  - header capture, bank registers, address map, cartridge RAM
 *  - ROM address out same cycle, RAM data out one cycle after the read
 */
module gb_cart_mbc (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  cart_pkg::dl_word_t              dl,
	input  logic                            dl_active,
	input  cart_pkg::cart_bus_t             bus,
	output logic [cart_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic                            rom_rd,
	output logic [7:0]                      cart_do
);
	import cart_pkg::*;

	cart_info_t            info;     // decoded header
	bank_state_t           banks;    // mapper registers
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_sel;  // console is in A000-BFFF

	// ------------------------------
	cart_header u_header (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl        (dl),
		.dl_active (dl_active),
		.info      (info)
	);

	mbc_regs u_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active), // registers restart with each new image
		.bus       (bus),
		.info      (info),
		.banks     (banks)
	);

	bank_map u_map (
		.bus      (bus),
		.info     (info),
		.banks    (banks),
		.rom_addr (rom_addr),
		.rom_rd   (rom_rd),
		.ram_addr (ram_addr),
		.ram_sel  (ram_sel)
	);

	cart_ram u_ram (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.info     (info),
		.banks    (banks),
		.ram_addr (ram_addr),
		.ram_sel  (ram_sel),
		.cart_do  (cart_do)
	);

endmodule

// File: sim/tb_cart_mbc.sv
/*
 * testbench for the cartridge mapper
 *  - download, bus write and bus read tasks
 *  - reference model of header decode, bank registers, address map and RAM
 *  - compare process on the falling edge, LFSR stimulus, watchdog
 */
module tb_cart_mbc;
	timeunit 1ns;
	timeprecision 1ps;
	import cart_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int KIND_OPS     = 200;            // random operations per mapper kind
	localparam int DIRECTED_OPS = 100;            // directed cycles incl. downloads, rounded up
	localparam int OP_COUNT     = DIRECTED_OPS + 5 * (KIND_OPS + 4);
	localparam int WATCHDOG_NS  = 2 * OP_COUNT * 3 * CLK_PERIOD;

	logic                  clk_sys = 1'b0;
	logic                  reset;
	dl_word_t              dl;
	logic                  dl_active;
	cart_bus_t             bus;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic                  rom_rd;
	logic [7:0]            cart_do;

	cart_info_t  m_info;                          // expected header decode
	bank_state_t m_banks;                         // expected mapper registers
	logic [7:0]  shadow_ram [0:(1 << RAM_ADDR_W)-1];
	bit          written [0:(1 << RAM_ADDR_W)-1]; // cell holds a known byte
	logic [15:0] lfsr_state = 16'd60;
	logic [7:0]  kind_codes [5] = '{8'h00, 8'h01, 8'h05, 8'h13, 8'h19};
	logic        rd_pend = 1'b0;                  // RAM read waiting for cart_do
	logic [7:0]  pend_val;
	logic [7:0]  pend_care;

	gb_cart_mbc dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl        (dl),
		.dl_active (dl_active),
		.bus       (bus),
		.rom_addr  (rom_addr),
		.rom_rd    (rom_rd),
		.cart_do   (cart_do)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	initial begin
		#(WATCHDOG_NS);
		$display("Simulation failed");
		$fatal(1, "watchdog expired, the test sequence did not complete in time");
	end

	// ------------------------------
	// random source
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v          = {v[14:0], lfsr_state[0]}; // one step per bit
			lfsr_state = next_lfsr(lfsr_state);
		end
		return v;
	endfunction

	// ------------------------------
	// reference model
	function automatic logic [ROM_ADDR_W-1:0] exp_rom_addr(input logic [15:0] a);
		logic [8:0] bank;
		case (m_info.kind)
			mbc_none: bank = {8'd0, a[14]};                  // 32k linear
			mbc_1:    bank = {2'b00, (m_banks.mbc1_mode ? 2'b00 : m_banks.ram_bank[1:0]),
				m_banks.rom_bank[4:0]};
			mbc_5:    bank = m_banks.rom_bank;
			default:  bank = {2'b00, m_banks.rom_bank[6:0]};
		endcase
		if (m_info.kind != mbc_none)
			bank = a[14] ? (bank & m_info.rom_mask) : 9'd0; // lower 16k fixed at bank 0
		return {bank, a[13:0]};
	endfunction

	function automatic logic [16:0] ram_index(input logic [15:0] a);
		logic [3:0] bank;
		case (m_info.kind)
			mbc_1:        bank = m_banks.mbc1_mode ? (m_banks.ram_bank & m_info.ram_mask) : 4'd0;
			mbc_3, mbc_5: bank = m_banks.ram_bank & m_info.ram_mask;
			default:      bank = 4'd0;
		endcase
		return {bank, a[12:0]};
	endfunction

	// expected cart_do, care marks the bits with a known value
	function automatic logic [7:0] exp_ram_byte(input logic [15:0] a, output logic [7:0] care);
		logic [16:0] idx;
		logic [7:0]  v;
		idx  = ram_index(a);
		v    = shadow_ram[idx];
		care = written[idx] ? 8'hFF : 8'h00;
		if (!m_banks.ram_enable) begin
			care = 8'hFF;
			return 8'hFF;
		end
		if (m_info.kind == mbc_3 && m_banks.rtc_sel) begin
			care = 8'hFF;
			return 8'h00;                                // clock register, no RTC
		end
		if (m_info.kind == mbc_2 && a < 16'hA200) begin
			care = care | 8'hF0;                         // 4-bit RAM, top reads high
			v    = v | 8'hF0;
		end
		return v;
	endfunction

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		logic [16:0] idx;
		idx = ram_index(a);
		case (a[15:13])
			3'd0: m_banks.ram_enable = (d[3:0] == RAM_ENABLE_KEY);
			3'd1: begin
				if (m_info.kind != mbc_5)
					m_banks.rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
				else if (a[12])
					m_banks.rom_bank[8] = d[0];
				else
					m_banks.rom_bank[7:0] = d;
			end
			3'd2: begin
				if (m_info.kind == mbc_5)
					m_banks.ram_bank = d[3:0];
				else if (m_info.kind == mbc_3 && d[3])
					m_banks.rtc_sel = 1'b1;
				else begin
					m_banks.rtc_sel  = 1'b0;
					m_banks.ram_bank = {2'b00, d[1:0]};
				end
			end
			3'd3: begin
				if (m_info.kind == mbc_1)
					m_banks.mbc1_mode = d[0];
			end
			3'd5: begin
				shadow_ram[idx] = d;                     // stored even while disabled
				written[idx]    = 1'b1;
			end
			default: ;
		endcase
	endtask

	// ------------------------------
	// stimulus, every task starts and ends 5 ns after a rising edge
	task automatic dl_beat(input logic [DL_ADDR_W-1:0] a, input logic [15:0] d);
		dl = '{wr: 1'b1, addr: a, data: d};
		@(posedge clk_sys);
		#5;
		dl.wr = 1'b0;
	endtask

	task automatic load_cart(input logic [7:0] code, input logic [7:0] rom_sz,
			input logic [7:0] ram_sz);
		dl_active = 1'b1;
		dl_beat(25'h134, 16'h4D47);                     // title, not decoded
		dl_beat(HDR_MBC_TYPE, {code, 8'h00});           // low byte SGB flag
		dl_beat(HDR_SIZES, {ram_sz, rom_sz});
		@(posedge clk_sys);
		#5;
		dl_active = 1'b0;
		m_info.kind = mbc_none;
		if (code >= 8'd1 && code <= 8'd3)
			m_info.kind = mbc_1;
		if (code == 8'd5 || code == 8'd6)
			m_info.kind = mbc_2;
		if (code >= 8'd15 && code <= 8'd19)
			m_info.kind = mbc_3;
		if (code >= 8'd25 && code <= 8'd30)
			m_info.kind = mbc_5;
		m_info.rom_mask = (rom_sz <= 8'd8) ? 9'((2 << rom_sz) - 1) : 9'd127;
		m_info.ram_mask = (ram_sz < 8'd3) ? 4'd0 : (ram_sz == 8'd3) ? 4'd3 : 4'd15;
		m_banks = '{rom_bank: 9'd1, default: '0};       // registers restart with the image
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		bus = '{addr: a, rd: 1'b0, wr: 1'b1, di: d};
		@(posedge clk_sys);
		#5;
		bus.wr = 1'b0;
		model_write(a, d);
	endtask

	task automatic bus_read(input logic [15:0] a);
		bus = '{addr: a, rd: 1'b1, wr: 1'b0, di: 8'h00};
		@(posedge clk_sys);
		#5;
		bus.rd = 1'b0;
	endtask

	// read with a fixed ROM address expected, checked mid-cycle
	task automatic expect_rom(input logic [15:0] a, input logic [ROM_ADDR_W-1:0] exp);
		bus = '{addr: a, rd: 1'b1, wr: 1'b0, di: 8'h00};
		#10;
		assert (rom_addr == exp) else
			report_error("rom_addr", 32'(exp), 32'(rom_addr));
		@(posedge clk_sys);
		#5;
		bus.rd = 1'b0;
	endtask

	task automatic random_ops(input logic [7:0] code);
		int          op;
		logic [15:0] a;
		logic [7:0]  d;
		load_cart(code, 8'(take_bits(4)), 8'(take_bits(3)));
		for (int i = 0; i < KIND_OPS; i++) begin
			op = int'(take_bits(2));
			a  = take_bits(15);                          // 0000-7FFF
			d  = 8'(take_bits(8));
			case (op)
				0: begin
					if (a[14:13] == 2'b00 && d[7])
						d = {4'h0, RAM_ENABLE_KEY};          // keep RAM on part of the time
					bus_write(a, d);
				end
				1:       bus_read(a);
				2:       bus_write(16'hA000 | {11'd0, a[4:0]}, d);
				default: bus_read(16'hA000 | {11'd0, a[4:0]});
			endcase
		end
	endtask

	task automatic report_error(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
		$display("Simulation failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	// ------------------------------
	// compare process, falling edge sits between drive and capture
	always @(negedge clk_sys) begin
		if (rd_pend) begin
			assert ((cart_do & pend_care) == (pend_val & pend_care)) else
				report_error("cart_do", 32'(pend_val), 32'(cart_do));
			rd_pend = 1'b0;
		end
		if (bus.rd && !bus.addr[15]) begin
			assert (rom_rd) else
				report_error("rom_rd", 32'd1, 32'(rom_rd));
			assert (rom_addr == exp_rom_addr(bus.addr)) else
				report_error("rom_addr", 32'(exp_rom_addr(bus.addr)), 32'(rom_addr));
		end else begin
			assert (!rom_rd) else                         // idle or above 7FFF
				report_error("rom_rd", 32'd0, 32'(rom_rd));
		end
		if (bus.rd && bus.addr[15:13] == 3'b101) begin
			pend_val = exp_ram_byte(bus.addr, pend_care); // cart_do follows next cycle
			rd_pend  = 1'b1;
		end
	end

	initial begin
		reset     = 1'b1;
		dl_active = 1'b0;
		dl        = '0;
		bus       = '0;
		m_info    = '{kind: mbc_none, rom_mask: 9'd0, ram_mask: 4'd0};
		m_banks   = '{rom_bank: 9'd1, default: '0};
		repeat (10) @(posedge clk_sys);
		#5;
		reset = 1'b0;

		// ROM only
		load_cart(8'h00, 8'h00, 8'h00);
		expect_rom(16'h0123, 23'h000123);
		expect_rom(16'h4567, 23'h004567);
		expect_rom(16'h7FFF, 23'h007FFF);
		bus_read(16'hA000);                              // no RAM, reads FF

		// MBC1, 512k then 2M
		load_cart(8'h01, 8'h04, 8'h00);
		bus_write(16'h2000, 8'h00);
		expect_rom(16'h4000, 23'h004000);                // bank 0 aliases to 1
		bus_write(16'h2100, 8'd35);
		expect_rom(16'h4001, 23'h00C001);                // 35 & 31 -> bank 3
		load_cart(8'h01, 8'h06, 8'h00);
		bus_write(16'h2000, 8'h02);
		bus_write(16'h4000, 8'h01);
		expect_rom(16'h4000, 23'h088000);                // bank 34 in mode 0
		bus_write(16'h6000, 8'h01);
		expect_rom(16'h4000, 23'h008000);                // mode 1 drops bits 6:5

		// MBC5, 8M
		load_cart(8'h19, 8'h08, 8'h00);
		bus_write(16'h2000, 8'h2C);
		bus_write(16'h3000, 8'h01);
		expect_rom(16'h4000, 23'h4B0000);                // bank 300
		bus_write(16'h2000, 8'h00);
		bus_write(16'h3000, 8'h00);
		expect_rom(16'h4010, 23'h000010);

		// 128k RAM behind MBC5
		load_cart(8'h1B, 8'h02, 8'h04);
		bus_read(16'hA005);
		bus_write(16'h0000, 8'h0A);
		bus_write(16'hA005, 8'h11);
		bus_write(16'h4000, 8'h07);
		bus_write(16'hA005, 8'h77);
		bus_read(16'hA005);
		bus_write(16'h4000, 8'h00);
		bus_read(16'hA005);
		bus_write(16'h0000, 8'h00);
		bus_read(16'hA005);

		// MBC2 nibble RAM, MBC3 clock select
		load_cart(8'h05, 8'h02, 8'h00);
		bus_write(16'h0000, 8'h0A);
		bus_write(16'hA010, 8'h3C);
		bus_read(16'hA010);
		load_cart(8'h13, 8'h02, 8'h03);
		bus_write(16'h0000, 8'h0A);
		bus_write(16'h4000, 8'h01);
		bus_write(16'hA020, 8'h5A);
		bus_write(16'h4000, 8'h08);
		bus_read(16'hA020);
		bus_write(16'h4000, 8'h01);
		bus_read(16'hA020);

		foreach (kind_codes[k])
			random_ops(kind_codes[k]);
		repeat (3) @(posedge clk_sys);                   // let the last cart_do compare run
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: gb_cart_mbc.f
hw/cart_pkg.sv
hw/cart_header.sv
hw/mbc_regs.sv
hw/bank_map.sv
hw/cart_ram.sv
hw/gb_cart_mbc.sv
sim/tb_cart_mbc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cartridge mapper testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cart_mbc -f gb_cart_mbc.f \
	&& ./obj_dir/Vtb_cart_mbc | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }
